//--- hdl/mem_bridge_pkg.sv
package mem_bridge_pkg;

  // --------------------------------------------------
  // processor-side memory port widths
  // --------------------------------------------------

  // word address, counted in words and not bytes
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  // requester tag, echoed back untouched
  localparam int TAG_WIDTH = 4;

  // --------------------------------------------------
  // request header
  // --------------------------------------------------

  typedef enum logic [0:0] {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  // the reverse header is a copy of the forward one
  typedef struct packed {
    mem_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [TAG_WIDTH-1:0]  tag;
  } mem_hdr_t;

endpackage

//--- hdl/mc_net_pkg.sv
package mc_net_pkg;

  import mem_bridge_pkg::*;

  // --------------------------------------------------
  // tile network widths
  // --------------------------------------------------

  // bank column coordinate, one column per cache bank
  localparam int X_WIDTH = 2;

  // word address inside one bank
  localparam int EPA_WIDTH = 6;

  // transaction id, carried in the reg_id field
  localparam int ID_WIDTH = 2;

  typedef enum logic [0:0] {
    MC_LOAD  = 1'b0,
    MC_STORE = 1'b1
  } mc_op_e;

  // request packet toward a bank
  typedef struct packed {
    mc_op_e                op;
    logic [X_WIDTH-1:0]    x_cord;
    logic [EPA_WIDTH-1:0]  epa;
    logic [ID_WIDTH-1:0]   reg_id;
    logic [DATA_WIDTH-1:0] data;
  } mc_packet_t;

  // return packet whose data is zero for a store
  typedef struct packed {
    logic [ID_WIDTH-1:0]   reg_id;
    logic [DATA_WIDTH-1:0] data;
  } mc_return_t;

endpackage

//--- hdl/mc_link_if.sv
interface mc_link_if
  import mc_net_pkg::*;
();

  // request path, valid/ready
  mc_packet_t req_packet;
  logic       req_v;
  logic       req_ready;

  // response path has no ready
  // the requester reserved a reorder entry before sending
  mc_return_t rsp_packet;
  logic       rsp_v;

  modport bridge (
    output req_packet,
    output req_v,
    input  req_ready,
    input  rsp_packet,
    input  rsp_v
  );

  modport bank (
    input  req_packet,
    input  req_v,
    output req_ready,
    output rsp_packet,
    output rsp_v
  );

endinterface

//--- hdl/dram_hash.sv
module dram_hash
  import mem_bridge_pkg::*;
  import mc_net_pkg::*;
#(
  parameter int NUM_BANKS_P   = 4,
  parameter int BLOCK_WORDS_P = 2
) (
  input  logic [ADDR_WIDTH-1:0] addr_i,
  output logic [X_WIDTH-1:0]    x_cord_o,
  output logic [EPA_WIDTH-1:0]  epa_o
);

  // blocks of BLOCK_WORDS_P words are dealt round robin over the columns
  // the row index and the offset in the block together give the local address
  always_comb
  begin : interleave
    logic [ADDR_WIDTH-1:0] block_idx;
    logic [ADDR_WIDTH-1:0] offset;
    logic [ADDR_WIDTH-1:0] row;

    block_idx = addr_i / ADDR_WIDTH'(BLOCK_WORDS_P);
    offset    = addr_i % ADDR_WIDTH'(BLOCK_WORDS_P);
    row       = block_idx / ADDR_WIDTH'(NUM_BANKS_P);

    x_cord_o = X_WIDTH'(block_idx % ADDR_WIDTH'(NUM_BANKS_P));
    epa_o    = EPA_WIDTH'(row * ADDR_WIDTH'(BLOCK_WORDS_P) + offset);
  end

endmodule

//--- hdl/reorder_fifo.sv
module reorder_fifo
  import mem_bridge_pkg::*;
  import mc_net_pkg::*;
#(
  parameter int OUTSTANDING_P = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,

  output logic [ID_WIDTH-1:0]   alloc_id_o,
  output logic                  alloc_v_o,
  input  logic                  alloc_yumi_i,

  input  logic [ID_WIDTH-1:0]   write_id_i,
  input  logic [DATA_WIDTH-1:0] write_data_i,
  input  logic                  write_v_i,

  output logic [ID_WIDTH-1:0]   deq_id_o,
  output logic [DATA_WIDTH-1:0] deq_data_o,
  output logic                  deq_v_o,
  input  logic                  deq_yumi_i
);

  localparam logic [ID_WIDTH-1:0] LAST_ID = ID_WIDTH'(OUTSTANDING_P - 1);

  logic [ID_WIDTH-1:0]      alloc_ptr_r;
  logic [ID_WIDTH-1:0]      deq_ptr_r;
  // used marks an id handed out, filled marks that its response has arrived
  logic [OUTSTANDING_P-1:0] used_r;
  logic [OUTSTANDING_P-1:0] filled_r;
  logic [DATA_WIDTH-1:0]    data_mem [OUTSTANDING_P];

  assign alloc_id_o = alloc_ptr_r;
  assign alloc_v_o  = ~used_r[alloc_ptr_r];

  // head leaves only once it has been filled
  assign deq_id_o   = deq_ptr_r;
  assign deq_v_o    = filled_r[deq_ptr_r];
  assign deq_data_o = data_mem[deq_ptr_r];

  // --------------------------------------------------
  // pointers and entry state
  // --------------------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      alloc_ptr_r <= '0;
      deq_ptr_r   <= '0;
      used_r      <= '0;
      filled_r    <= '0;
    end
    else
    begin
      if (alloc_yumi_i)
      begin
        used_r[alloc_ptr_r] <= 1'b1;
        alloc_ptr_r         <= (alloc_ptr_r == LAST_ID) ? '0 : alloc_ptr_r + 1'b1;
      end
      if (write_v_i)
        filled_r[write_id_i] <= 1'b1;
      // a filled head can never be the id being allocated
      if (deq_yumi_i)
      begin
        used_r[deq_ptr_r]   <= 1'b0;
        filled_r[deq_ptr_r] <= 1'b0;
        deq_ptr_r           <= (deq_ptr_r == LAST_ID) ? '0 : deq_ptr_r + 1'b1;
      end
    end
  end

  // responses land by id in any order
  always_ff @(posedge clk_i)
  begin
    if (write_v_i)
      data_mem[write_id_i] <= write_data_i;
  end

  // a bank answers only ids that are out and not yet answered
  assert property (@(posedge clk_i) disable iff (rst_i)
    write_v_i |-> used_r[write_id_i] && !filled_r[write_id_i])
  else
    $error("reorder write to id %0d that is not pending", write_id_i);

endmodule

//--- hdl/dram_bridge.sv
module dram_bridge
  import mem_bridge_pkg::*;
  import mc_net_pkg::*;
#(
  parameter int OUTSTANDING_P = 4,
  parameter int NUM_BANKS_P   = 4,
  parameter int BLOCK_WORDS_P = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  mem_hdr_t              mem_fwd_hdr_i,
  input  logic [DATA_WIDTH-1:0] mem_fwd_data_i,
  input  logic                  mem_fwd_v_i,
  output logic                  mem_fwd_ready_o,

  output mem_hdr_t              mem_rev_hdr_o,
  output logic [DATA_WIDTH-1:0] mem_rev_data_o,
  output logic                  mem_rev_v_o,
  input  logic                  mem_rev_ready_i,

  mc_link_if.bridge             link
);

  if ($clog2(OUTSTANDING_P) != ID_WIDTH)
  begin : g_id_width_check
    $error("ID_WIDTH does not match OUTSTANDING_P");
  end

  logic [ID_WIDTH-1:0]  alloc_id;
  logic                 alloc_v;
  logic                 fwd_yumi;
  logic [ID_WIDTH-1:0]  deq_id;
  logic                 deq_v;
  logic                 deq_yumi;
  logic [X_WIDTH-1:0]   dram_x;
  logic [EPA_WIDTH-1:0] dram_epa;
  mc_packet_t           req_packet;

  // header of each request in flight, indexed by its transaction id
  mem_hdr_t             hdr_mem [OUTSTANDING_P];

  dram_hash #(
    .NUM_BANKS_P   (NUM_BANKS_P),
    .BLOCK_WORDS_P (BLOCK_WORDS_P)
  ) hash (
    .addr_i   (mem_fwd_hdr_i.addr),
    .x_cord_o (dram_x),
    .epa_o    (dram_epa)
  );

  reorder_fifo #(
    .OUTSTANDING_P (OUTSTANDING_P)
  ) rob (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .alloc_id_o   (alloc_id),
    .alloc_v_o    (alloc_v),
    .alloc_yumi_i (fwd_yumi),
    .write_id_i   (link.rsp_packet.reg_id),
    .write_data_i (link.rsp_packet.data),
    .write_v_i    (link.rsp_v),
    .deq_id_o     (deq_id),
    .deq_data_o   (mem_rev_data_o),
    .deq_v_o      (deq_v),
    .deq_yumi_i   (deq_yumi)
  );

  // --------------------------------------------------
  // outgoing request
  // --------------------------------------------------

  // accept needs a free id and a free slot in the target column
  assign mem_fwd_ready_o = alloc_v & link.req_ready;
  assign fwd_yumi        = mem_fwd_v_i & mem_fwd_ready_o;

  always_comb
  begin
    req_packet        = '0;
    req_packet.op     = (mem_fwd_hdr_i.op == MEM_WR) ? MC_STORE : MC_LOAD;
    req_packet.x_cord = dram_x;
    req_packet.epa    = dram_epa;
    req_packet.reg_id = alloc_id;
    req_packet.data   = mem_fwd_data_i;
  end

  // the id moves only on accept, so a stalled packet stays stable
  assign link.req_packet = req_packet;
  assign link.req_v      = mem_fwd_v_i & alloc_v;

  always_ff @(posedge clk_i)
  begin
    if (fwd_yumi)
      hdr_mem[alloc_id] <= mem_fwd_hdr_i;
  end

  // --------------------------------------------------
  // in-order return
  // --------------------------------------------------

  assign mem_rev_hdr_o = hdr_mem[deq_id];
  assign mem_rev_v_o   = deq_v;
  assign deq_yumi      = deq_v & mem_rev_ready_i;

  // header memory and reorder head must hold together under stall
  assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rev_v_o && !mem_rev_ready_i |=>
      mem_rev_v_o && $stable(mem_rev_hdr_o) && $stable(mem_rev_data_o))
  else
    $error("reverse response changed while stalled");

endmodule

//--- hdl/dram_bank_array.sv
module dram_bank_array
  import mem_bridge_pkg::*;
  import mc_net_pkg::*;
#(
  parameter int NUM_BANKS_P = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,
  mc_link_if.bank link
);

  if ($clog2(NUM_BANKS_P) != X_WIDTH)
  begin : g_x_width_check
    $error("X_WIDTH does not match NUM_BANKS_P");
  end

  localparam int DEPTH     = 2 ** EPA_WIDTH;
  // column x waits 2x cycles after the first one
  localparam int CNT_WIDTH = X_WIDTH + 1;

  logic [DATA_WIDTH-1:0] mem_r [NUM_BANKS_P][DEPTH];

  // one request slot per column
  logic [NUM_BANKS_P-1:0] slot_v_r;
  logic [CNT_WIDTH-1:0]   slot_cnt_r [NUM_BANKS_P];
  mc_op_e                 slot_op_r  [NUM_BANKS_P];
  logic [EPA_WIDTH-1:0]   slot_epa_r [NUM_BANKS_P];
  logic [ID_WIDTH-1:0]    slot_id_r  [NUM_BANKS_P];

  logic [NUM_BANKS_P-1:0] done;
  logic [X_WIDTH-1:0]     grant;
  logic [X_WIDTH-1:0]     req_x;
  logic                   accept;
  mc_return_t             rsp;

  assign req_x          = link.req_packet.x_cord;
  assign link.req_ready = ~slot_v_r[req_x];
  assign accept         = link.req_v & link.req_ready;

  // --------------------------------------------------
  // response select
  // --------------------------------------------------

  always_comb
  begin
    for (int i = 0; i < NUM_BANKS_P; i++)
      done[i] = slot_v_r[i] && (slot_cnt_r[i] == '0);
  end

  // lowest finished column goes first while the rest wait with count at zero
  always_comb
  begin
    grant = '0;
    for (int i = NUM_BANKS_P - 1; i >= 0; i--)
    begin
      if (done[i])
        grant = X_WIDTH'(i);
    end
  end

  always_comb
  begin
    rsp.reg_id = slot_id_r[grant];
    rsp.data   = (slot_op_r[grant] == MC_LOAD) ? mem_r[grant][slot_epa_r[grant]] : '0;
  end

  assign link.rsp_packet = rsp;
  assign link.rsp_v      = |done;

  // --------------------------------------------------
  // slot control
  // --------------------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      slot_v_r <= '0;
      for (int i = 0; i < NUM_BANKS_P; i++)
        slot_cnt_r[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_BANKS_P; i++)
      begin
        if (slot_v_r[i] && slot_cnt_r[i] != '0)
          slot_cnt_r[i] <= slot_cnt_r[i] - 1'b1;
      end
      if (link.rsp_v)
        slot_v_r[grant] <= 1'b0;
      // an accepting column is empty and never the granted one
      if (accept)
      begin
        slot_v_r[req_x]   <= 1'b1;
        slot_cnt_r[req_x] <= {req_x, 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      slot_op_r[req_x]  <= link.req_packet.op;
      slot_epa_r[req_x] <= link.req_packet.epa;
      slot_id_r[req_x]  <= link.req_packet.reg_id;
    end
  end

  // stores commit at accept, loads read when their slot completes
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int b = 0; b < NUM_BANKS_P; b++)
        for (int w = 0; w < DEPTH; w++)
          mem_r[b][w] <= '0;
    end
    else if (accept && link.req_packet.op == MC_STORE)
      mem_r[req_x][link.req_packet.epa] <= link.req_packet.data;
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    link.rsp_v |-> !$isunknown(link.rsp_packet.reg_id))
  else
    $error("bank response with unknown reg_id");

endmodule

//--- hdl/dram_subsystem_top.sv
module dram_subsystem_top
  import mem_bridge_pkg::*;
#(
  parameter int OUTSTANDING_P = 4,
  parameter int NUM_BANKS_P   = 4,
  parameter int BLOCK_WORDS_P = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  mem_hdr_t              mem_fwd_hdr_i,
  input  logic [DATA_WIDTH-1:0] mem_fwd_data_i,
  input  logic                  mem_fwd_v_i,
  output logic                  mem_fwd_ready_o,

  output mem_hdr_t              mem_rev_hdr_o,
  output logic [DATA_WIDTH-1:0] mem_rev_data_o,
  output logic                  mem_rev_v_o,
  input  logic                  mem_rev_ready_i
);

  // network link between the bridge and the bank row
  mc_link_if link ();

  dram_bridge #(
    .OUTSTANDING_P (OUTSTANDING_P),
    .NUM_BANKS_P   (NUM_BANKS_P),
    .BLOCK_WORDS_P (BLOCK_WORDS_P)
  ) bridge (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .mem_fwd_hdr_i   (mem_fwd_hdr_i),
    .mem_fwd_data_i  (mem_fwd_data_i),
    .mem_fwd_v_i     (mem_fwd_v_i),
    .mem_fwd_ready_o (mem_fwd_ready_o),
    .mem_rev_hdr_o   (mem_rev_hdr_o),
    .mem_rev_data_o  (mem_rev_data_o),
    .mem_rev_v_o     (mem_rev_v_o),
    .mem_rev_ready_i (mem_rev_ready_i),
    .link            (link.bridge)
  );

  dram_bank_array #(
    .NUM_BANKS_P (NUM_BANKS_P)
  ) banks (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .link  (link.bank)
  );

endmodule

//--- testbench/tb_dram_subsystem.sv
module tb_dram_subsystem
  import mem_bridge_pkg::*;
();

  localparam int OUTSTANDING_P = 4;
  localparam int RANDOM_REQS   = 200;
  // about 250 requests over all tests, none slower than 20 cycles
  localparam int MAX_REQUESTS   = 250;
  localparam int MAX_REQ_CYCLES = 20;
  localparam int TIMEOUT_CYCLES = MAX_REQUESTS * MAX_REQ_CYCLES;
  localparam int STALL_LEN      = 1024;

  logic                  clk_i;
  logic                  rst_i;
  mem_hdr_t              mem_fwd_hdr_i;
  logic [DATA_WIDTH-1:0] mem_fwd_data_i;
  logic                  mem_fwd_v_i;
  logic                  mem_fwd_ready_o;
  mem_hdr_t              mem_rev_hdr_o;
  logic [DATA_WIDTH-1:0] mem_rev_data_o;
  logic                  mem_rev_v_o;
  logic                  mem_rev_ready_i;

  integer seed;
  int     cycles = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err_start;
  string  cur_test = "reset";

  // expected responses in issue order, and a model of the whole word space
  mem_hdr_t              exp_hdr_q [$];
  logic [DATA_WIDTH-1:0] exp_data_q [$];
  logic [DATA_WIDTH-1:0] ref_mem [2**ADDR_WIDTH];

  logic rev_ready_req;
  logic stall_en;
  bit   stall_pat [STALL_LEN];
  int   stall_idx = 0;

  dram_subsystem_top #(
    .OUTSTANDING_P (OUTSTANDING_P),
    .NUM_BANKS_P   (4),
    .BLOCK_WORDS_P (2)
  ) dut_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .mem_fwd_hdr_i   (mem_fwd_hdr_i),
    .mem_fwd_data_i  (mem_fwd_data_i),
    .mem_fwd_v_i     (mem_fwd_v_i),
    .mem_fwd_ready_o (mem_fwd_ready_o),
    .mem_rev_hdr_o   (mem_rev_hdr_o),
    .mem_rev_data_o  (mem_rev_data_o),
    .mem_rev_v_o     (mem_rev_v_o),
    .mem_rev_ready_i (mem_rev_ready_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // reverse ready follows the test, or a precomputed stall pattern
  initial
  begin
    mem_rev_ready_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #10;
      if (stall_en)
      begin
        mem_rev_ready_i = stall_pat[stall_idx];
        stall_idx       = (stall_idx + 1) % STALL_LEN;
      end
      else
        mem_rev_ready_i = rev_ready_req;
    end
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------

  task automatic check_hdr(input mem_hdr_t exp, input mem_hdr_t act);
    checks++;
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: header expected %s addr %h tag %h, actual %s addr %h tag %h",
               cur_test, exp.op.name(), exp.addr, exp.tag, act.op.name(), act.addr, act.tag);
      errors++;
    end
  endtask

  task automatic check_data(input logic [DATA_WIDTH-1:0] exp, input logic [DATA_WIDTH-1:0] act);
    checks++;
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: data expected %h, actual %h", cur_test, exp, act);
      errors++;
    end
  endtask

  // a transfer seen at the falling edge completes on the next rising edge
  initial
  begin
    forever
    begin
      @(negedge clk_i);
      if (!rst_i && mem_rev_v_o && mem_rev_ready_i)
      begin
        if (exp_hdr_q.size() == 0)
        begin
          $display("%s: response arrived with no request outstanding", cur_test);
          errors++;
        end
        else
        begin
          check_hdr(exp_hdr_q.pop_front(), mem_rev_hdr_o);
          check_data(exp_data_q.pop_front(), mem_rev_data_o);
        end
      end
    end
  end

  // --------------------------------------------------
  // request helpers
  // --------------------------------------------------

  // called 10 units after a rising edge, returns at the same point
  task automatic send_req(input mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data, input logic [TAG_WIDTH-1:0] tag);
    mem_hdr_t hdr;
    hdr.op         = op;
    hdr.addr       = addr;
    hdr.tag        = tag;
    mem_fwd_hdr_i  = hdr;
    mem_fwd_data_i = data;
    mem_fwd_v_i    = 1'b1;
    @(negedge clk_i);
    while (!mem_fwd_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #10;
    mem_fwd_v_i = 1'b0;
    exp_hdr_q.push_back(hdr);
    // stores answer with zero, loads with the word as it stands at issue
    if (op == MEM_WR)
    begin
      exp_data_q.push_back('0);
      ref_mem[addr] = data;
    end
    else
      exp_data_q.push_back(ref_mem[addr]);
  endtask

  task automatic wait_idle();
    while (exp_hdr_q.size() != 0)
      @(posedge clk_i);
    #10;
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_err_start)
      $display("%s: ok", cur_test);
    else
    begin
      $display("%s: %0d errors", cur_test, errors - test_err_start);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic after_reset();
    begin_test("after_reset");
    if (mem_rev_v_o !== 1'b0)
    begin
      $display("after_reset: reverse valid is not low after reset");
      errors++;
    end
    while (mem_fwd_ready_o !== 1'b1)
    begin
      @(posedge clk_i);
      #10;
    end
    send_req(MEM_RD, 8'h5a, '0, 4'h1);
    wait_idle();
    finish_test();
  endtask

  task automatic write_then_read();
    begin_test("write_then_read");
    send_req(MEM_WR, 8'h21, 32'hdeadbeef, 4'h2);
    send_req(MEM_RD, 8'h21, '0, 4'h3);
    wait_idle();
    finish_test();
  endtask

  // address 6 is block 3 on column 3, address 8 is block 4 on column 0
  task automatic column_order();
    begin_test("column_order");
    send_req(MEM_WR, 8'h06, 32'h0600_c0de, 4'h4);
    send_req(MEM_WR, 8'h08, 32'h0800_c0de, 4'h5);
    wait_idle();
    send_req(MEM_RD, 8'h06, '0, 4'h6);
    send_req(MEM_RD, 8'h08, '0, 4'h7);
    wait_idle();
    finish_test();
  endtask

  task automatic back_pressure();
    begin_test("back_pressure");
    rev_ready_req = 1'b0;
    // one request per column fills every reorder id
    send_req(MEM_WR, 8'h00, 32'h1111_0000, 4'h8);
    send_req(MEM_RD, 8'h02, '0, 4'h9);
    send_req(MEM_WR, 8'h04, 32'h2222_0004, 4'ha);
    send_req(MEM_RD, 8'h06, '0, 4'hb);
    mem_fwd_hdr_i.op   = MEM_RD;
    mem_fwd_hdr_i.addr = 8'h00;
    mem_fwd_hdr_i.tag  = 4'hc;
    mem_fwd_v_i        = 1'b1;
    repeat (20)
    begin
      @(negedge clk_i);
      if (mem_fwd_ready_o)
      begin
        $display("back_pressure: request accepted with all reorder ids in use");
        errors++;
      end
    end
    @(posedge clk_i);
    #10;
    mem_fwd_v_i   = 1'b0;
    rev_ready_req = 1'b1;
    send_req(MEM_RD, 8'h00, '0, 4'hc);
    wait_idle();
    finish_test();
  endtask

  task automatic random_mix();
    mem_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [TAG_WIDTH-1:0]  tag;
    begin_test("random_mix");
    for (int i = 0; i < STALL_LEN; i++)
      stall_pat[i] = ($random(seed) & 3) != 0;
    stall_en = 1'b1;
    for (int n = 0; n < RANDOM_REQS; n++)
    begin
      op   = ($random(seed) & 1) ? MEM_WR : MEM_RD;
      addr = ADDR_WIDTH'($random(seed));
      data = $random(seed);
      tag  = TAG_WIDTH'($random(seed));
      send_req(op, addr, data, tag);
    end
    wait_idle();
    stall_en = 1'b0;
    finish_test();
  endtask

  initial
  begin
    seed           = 32'hf95572ec;
    rst_i          = 1'b1;
    mem_fwd_hdr_i  = '0;
    mem_fwd_data_i = '0;
    mem_fwd_v_i    = 1'b0;
    rev_ready_req  = 1'b1;
    stall_en       = 1'b0;
    for (int i = 0; i < 2**ADDR_WIDTH; i++)
      ref_mem[i] = '0;
    repeat (5) @(posedge clk_i);
    #10;
    rst_i = 1'b0;

    after_reset();
    write_then_read();
    column_order();
    back_pressure();
    random_mix();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- src.f
hdl/mem_bridge_pkg.sv
hdl/mc_net_pkg.sv
hdl/mc_link_if.sv
hdl/dram_hash.sv
hdl/reorder_fifo.sv
hdl/dram_bridge.sv
hdl/dram_bank_array.sv
hdl/dram_subsystem_top.sv
testbench/tb_dram_subsystem.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dram_subsystem -f src.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && exit 0 || exit 1
